//--- all.f
hw/vga_pkg.sv
hw/vga_timing.sv
hw/raster_delay.sv
hw/pixel_encoder.sv
hw/vga_top.sv
tb/vga_tb.sv

//--- hw/pixel_encoder.sv
module pixel_encoder (
    input  logic                  clk,
    input  logic                  rst,
    input  vga_pkg::raster_beat_t beat,
    input  vga_pkg::color332_t    color,
    output vga_pkg::vga_pins_t    pins
);

    vga_pkg::vga_pins_t pins_d;

    // abc -> abcabcab
    function automatic logic [7:0] widen3(input logic [2:0] c);
        return {c, c, c[2:1]};
    endfunction

    // ab -> abababab
    function automatic logic [7:0] widen2(input logic [1:0] c);
        return {4{c}};
    endfunction

    always_comb begin
        pins_d.hsync = beat.hsync;
        pins_d.vsync = beat.vsync;
        pins_d.blank = beat.active;  // pin is low during blanking
        if (beat.active) begin
            pins_d.red   = widen3(color.red);
            pins_d.green = widen3(color.green);
            pins_d.blue  = widen2(color.blue);
        end else begin
            // force black in porches and sync
            pins_d.red   = 8'h00;
            pins_d.green = 8'h00;
            pins_d.blue  = 8'h00;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pins <= vga_pkg::PINS_IDLE;
        end else begin
            pins <= pins_d;  // all pins change on the same edge
        end
    end

endmodule

//--- hw/raster_delay.sv
module raster_delay (
    input  logic                  clk,
    input  logic                  rst,
    input  vga_pkg::raster_beat_t beat_in,
    output vga_pkg::raster_beat_t beat_out
);

    // one stage per cycle of frame source latency
    vga_pkg::raster_beat_t stage_q [vga_pkg::SOURCE_LATENCY];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // idle beats keep a stray sync pulse off the pins after reset
            for (int i = 0; i < vga_pkg::SOURCE_LATENCY; i++) begin
                stage_q[i] <= vga_pkg::BEAT_IDLE;
            end
        end else begin
            stage_q[0] <= beat_in;
            for (int i = 1; i < vga_pkg::SOURCE_LATENCY; i++) begin
                stage_q[i] <= stage_q[i-1];  // older beats move along
            end
        end
    end

    // oldest beat lines up with the colour answer
    assign beat_out = stage_q[vga_pkg::SOURCE_LATENCY-1];

endmodule

//--- hw/vga_pkg.sv
package vga_pkg;

    // 640x480 at 60 Hz on a 25 MHz pixel clock
    localparam int H_ACTIVE = 640;  // visible pixels
    localparam int H_FRONT  = 16;
    localparam int H_PULSE  = 96;   // hsync low
    localparam int H_BACK   = 48;

    localparam int V_ACTIVE = 480;  // visible lines
    localparam int V_FRONT  = 10;
    localparam int V_PULSE  = 2;    // lines with vsync low
    localparam int V_BACK   = 33;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_PULSE + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_PULSE + V_BACK;

    localparam int COORD_W = 10;

    // cycles from coordinate request to colour answer
    localparam int SOURCE_LATENCY = 1;

    typedef logic [COORD_W-1:0] coord_t;

    typedef enum logic [1:0] {
        h_phase_active = 2'd0,
        h_phase_front  = 2'd1,
        h_phase_pulse  = 2'd2,
        h_phase_back   = 2'd3
    } h_phase_t;

    typedef enum logic [1:0] {
        v_phase_active = 2'd0,
        v_phase_front  = 2'd1,
        v_phase_pulse  = 2'd2,
        v_phase_back   = 2'd3
    } v_phase_t;

    typedef struct packed {
        logic [2:0] red;
        logic [2:0] green;
        logic [1:0] blue;
    } color332_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   hsync;   // active low
        logic   vsync;   // active low
        logic   active;
    } raster_beat_t;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       blank;   // low while blanking
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } vga_pins_t;

    // idle values with syncs released and everything blanked
    localparam raster_beat_t BEAT_IDLE = '{x: '0, y: '0, hsync: 1'b1, vsync: 1'b1, active: 1'b0};
    localparam vga_pins_t PINS_IDLE = '{hsync: 1'b1, vsync: 1'b1, blank: 1'b0,
                                        red: 8'h00, green: 8'h00, blue: 8'h00};

endpackage

//--- hw/vga_timing.sv
module vga_timing (
    input  logic                  clk,
    input  logic                  rst,
    output vga_pkg::raster_beat_t beat
);

    vga_pkg::h_phase_t h_phase, h_phase_next;
    vga_pkg::v_phase_t v_phase, v_phase_next;

    vga_pkg::coord_t h_count, h_count_next;  // pixel within current h phase
    vga_pkg::coord_t v_count, v_count_next;  // line within current v phase

    logic h_end;      // last clock of the current h phase
    logic v_end;      // last clock of the last line of the current v phase
    logic line_done;  // end of back porch steps the vertical machine

    // last count value of each phase
    function automatic vga_pkg::coord_t h_last(input vga_pkg::h_phase_t ph);
        case (ph)
            vga_pkg::h_phase_active: return vga_pkg::coord_t'(vga_pkg::H_ACTIVE - 1);
            vga_pkg::h_phase_front:  return vga_pkg::coord_t'(vga_pkg::H_FRONT - 1);
            vga_pkg::h_phase_pulse:  return vga_pkg::coord_t'(vga_pkg::H_PULSE - 1);
            default:                 return vga_pkg::coord_t'(vga_pkg::H_BACK - 1);
        endcase
    endfunction

    function automatic vga_pkg::coord_t v_last(input vga_pkg::v_phase_t ph);
        case (ph)
            vga_pkg::v_phase_active: return vga_pkg::coord_t'(vga_pkg::V_ACTIVE - 1);
            vga_pkg::v_phase_front:  return vga_pkg::coord_t'(vga_pkg::V_FRONT - 1);
            vga_pkg::v_phase_pulse:  return vga_pkg::coord_t'(vga_pkg::V_PULSE - 1);
            default:                 return vga_pkg::coord_t'(vga_pkg::V_BACK - 1);
        endcase
    endfunction

    // horizontal machine
    always_comb begin
        h_end     = (h_count == h_last(h_phase));
        line_done = h_end && (h_phase == vga_pkg::h_phase_back);

        h_count_next = h_count + 1'b1;
        h_phase_next = h_phase;
        if (h_end) begin
            h_count_next = '0;  // reload for next phase
            case (h_phase)
                vga_pkg::h_phase_active: h_phase_next = vga_pkg::h_phase_front;
                vga_pkg::h_phase_front:  h_phase_next = vga_pkg::h_phase_pulse;
                vga_pkg::h_phase_pulse:  h_phase_next = vga_pkg::h_phase_back;
                default:                 h_phase_next = vga_pkg::h_phase_active;
            endcase
        end
    end

    // vertical machine counting lines
    always_comb begin
        v_end = line_done && (v_count == v_last(v_phase));

        v_count_next = v_count;
        v_phase_next = v_phase;
        if (line_done) begin
            v_count_next = v_count + 1'b1;
        end
        if (v_end) begin
            v_count_next = '0;
            case (v_phase)
                vga_pkg::v_phase_active: v_phase_next = vga_pkg::v_phase_front;
                vga_pkg::v_phase_front:  v_phase_next = vga_pkg::v_phase_pulse;
                vga_pkg::v_phase_pulse:  v_phase_next = vga_pkg::v_phase_back;
                default:                 v_phase_next = vga_pkg::v_phase_active;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_phase <= vga_pkg::h_phase_active;
            v_phase <= vga_pkg::v_phase_active;
            h_count <= '0;
            v_count <= '0;
        end else begin
            h_phase <= h_phase_next;
            v_phase <= v_phase_next;
            h_count <= h_count_next;
            v_count <= v_count_next;
        end
    end

    // beat decode
    always_comb begin
        beat.x      = (h_phase == vga_pkg::h_phase_active) ? h_count : '0;
        beat.y      = (v_phase == vga_pkg::v_phase_active) ? v_count : '0;
        beat.hsync  = (h_phase != vga_pkg::h_phase_pulse);
        beat.vsync  = (v_phase != vga_pkg::v_phase_pulse);
        beat.active = (h_phase == vga_pkg::h_phase_active)
                   && (v_phase == vga_pkg::v_phase_active);
    end

endmodule

//--- hw/vga_top.sv
module vga_top (
    input  logic               clk,
    input  logic               rst,
    input  vga_pkg::color332_t color_in,  // RRRGGGBB arriving one cycle after x_out/y_out
    output logic [9:0]         x_out,
    output logic [9:0]         y_out,
    output logic               hsync,
    output logic               vsync,
    output logic               blank,
    output logic [7:0]         red,
    output logic [7:0]         green,
    output logic [7:0]         blue
);

    vga_pkg::raster_beat_t beat;      // current coordinate sent to frame source
    vga_pkg::raster_beat_t beat_dly;  // aligned with color_in
    vga_pkg::vga_pins_t    pins;

    vga_timing vga_timing_i (
        .clk  (clk),
        .rst  (rst),
        .beat (beat)
    );

    raster_delay raster_delay_i (
        .clk      (clk),
        .rst      (rst),
        .beat_in  (beat),
        .beat_out (beat_dly)
    );

    pixel_encoder pixel_encoder_i (
        .clk   (clk),
        .rst   (rst),
        .beat  (beat_dly),
        .color (color_in),
        .pins  (pins)
    );

    // pixel request
    assign x_out = beat.x;
    assign y_out = beat.y;

    assign hsync = pins.hsync;
    assign vsync = pins.vsync;
    assign blank = pins.blank;
    assign red   = pins.red;
    assign green = pins.green;
    assign blue  = pins.blue;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the VGA testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module vga_tb -f all.f -o vga_sim > build.log 2>&1 \
    && ./obj_dir/vga_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAILED"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "no result in log"; exit 1; }
echo "PASSED"

//--- tb/vga_input.txt
# P name x y colour(RRRGGGBB hex) red green blue (hex)
# T hsync_width line_period vsync_lines frame_lines active_per_line
T 96 800 2 525 640
P origin_white 0 0 ff ff ff ff
P second_black 1 0 00 00 00 00
P right_red 639 0 e0 ff 00 00
P left_green 0 1 1c 00 ff 00
P mid_blue 320 240 03 00 00 ff
P mid_grey 321 240 92 92 92 aa
P teal_6d 100 50 6d 6d 6d 55
P mix_a5 200 100 a5 b6 24 55
P mix_4a 400 300 4a 49 49 aa
P mix_37 17 33 37 24 b6 ff
P mix_c9 600 450 c9 db 49 55
P red_lsb 5 5 20 24 00 00
P green_lsb 6 5 04 00 24 00
P blue_01 7 5 01 00 00 55
P blue_10 8 5 02 00 00 aa
P red_msb 9 5 80 92 00 00
P green_msb 10 5 10 00 92 00
P bottom_left 0 479 db db db ff
P bottom_right 639 479 7e 6d ff aa

//--- tb/vga_tb.sv
module vga_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_PIX = 32;
    localparam int FRAME_CYCLES = vga_pkg::H_TOTAL * vga_pkg::V_TOTAL;
    localparam int LIMIT_CYCLES = 2 * FRAME_CYCLES + 100;  // two frames plus reset

    logic               clk;
    logic               rst;
    vga_pkg::color332_t color_in;
    logic [9:0]         x_out;
    logic [9:0]         y_out;
    logic               hsync;
    logic               vsync;
    logic               blank;
    logic [7:0]         red;
    logic [7:0]         green;
    logic [7:0]         blue;

    // pixel lines from the data file
    string              pix_name [MAX_PIX];
    vga_pkg::color332_t pix_col [MAX_PIX];
    int                 pix_r [MAX_PIX];
    int                 pix_g [MAX_PIX];
    int                 pix_b [MAX_PIX];
    bit                 pix_seen [MAX_PIX];
    int                 pix_at [int];  // y*1024+x to line index
    int                 pix_count;
    int exp_hsync_w, exp_line, exp_vsync_lines, exp_frame_lines, exp_active;

    int errors, tests_passed, tests_failed, reset_errs, cycle_count;
    bit file_ok, run_done, line_checked, hwidth_checked, vwidth_checked;
    logic [15:0] lfsr_state;
    vga_pkg::color332_t next_color;
    int hist1, hist2;  // pixel line index of the beats one and two cycles back
    int hfall_c, vfall_c, brise_c, first_run, bad_runs, bad_black, bad_coords, blank_lines;
    logic hsync_prev, vsync_prev, blank_prev;

    vga_top vga_top_i (
        .clk      (clk),
        .rst      (rst),
        .color_in (color_in),
        .x_out    (x_out),
        .y_out    (y_out),
        .hsync    (hsync),
        .vsync    (vsync),
        .blank    (blank),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_lfsr_byte(output logic [7:0] value);
        for (int i = 0; i < 8; i++) begin
            value = {value[6:0], lfsr_state[15]};
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
        end
    endtask

    // widen a colour field to 8 bits by repeating it from the msb down
    function automatic int replicate(input int field, input int width);
        int result;
        result = 0;
        for (int i = 0; i < 8; i++) begin
            result = (result << 1) | ((field >> (width - 1 - (i % width))) & 1);
        end
        return result;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s passed", name);
            tests_passed++;
        end else begin
            $display("test %s failed", name);
            tests_failed++;
        end
    endtask

    task automatic load_cases();
        int fd, n, px, py, col, er, eg, eb;
        string line, kind, nm;
        fd = $fopen("tb/vga_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/vga_input.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, "%s", kind);
                    if (n == 1 && kind == "P" && pix_count < MAX_PIX) begin
                        n = $sscanf(line, "%s %s %d %d %h %h %h %h",
                                    kind, nm, px, py, col, er, eg, eb);
                        pix_name[pix_count] = nm;
                        pix_col[pix_count]  = col[7:0];
                        pix_r[pix_count]    = er;
                        pix_g[pix_count]    = eg;
                        pix_b[pix_count]    = eb;
                        pix_at[py * 1024 + px] = pix_count;
                        pix_count++;
                    end else if (n == 1 && kind == "T") begin
                        n = $sscanf(line, "%s %d %d %d %d %d", kind, exp_hsync_w,
                                    exp_line, exp_vsync_lines, exp_frame_lines, exp_active);
                        file_ok = (n == 6);
                    end
                end
            end
            $fclose(fd);
            if (!file_ok) begin
                $display("the data file holds no complete timing line");
                errors++;
            end
        end
    endtask

    task automatic check_idle(input string tag);
        check_value({tag, " hsync"}, 1, int'(hsync));
        check_value({tag, " vsync"}, 1, int'(vsync));
        check_value({tag, " blank"}, 0, int'(blank));
        check_value({tag, " colour"}, 0, int'({red, green, blue}));
    endtask

    task automatic check_pixel(input int k);
        int errs0;
        int col;
        errs0 = errors;
        col = int'(pix_col[k]);
        check_value({pix_name[k], " red"}, pix_r[k], int'(red));
        check_value({pix_name[k], " green"}, pix_g[k], int'(green));
        check_value({pix_name[k], " blue"}, pix_b[k], int'(blue));
        // the file values must agree with the replication rule as well
        check_value({pix_name[k], " red rule"}, replicate((col >> 5) & 7, 3), pix_r[k]);
        check_value({pix_name[k], " green rule"}, replicate((col >> 2) & 7, 3), pix_g[k]);
        check_value({pix_name[k], " blue rule"}, replicate(col & 3, 2), pix_b[k]);
        pix_seen[k] = 1'b1;
        end_test(pix_name[k], errs0);
    endtask

    // edge measurements on the output pins at step c
    task automatic watch_pins(input int c);
        int errs0;
        errs0 = errors;
        if (hsync_prev && !hsync) begin
            if (hfall_c < 0) begin
                check_value("first_hsync fall", vga_pkg::H_ACTIVE + vga_pkg::H_FRONT + 2, c);
                end_test("first_hsync", errs0);
            end else if (!line_checked) begin
                check_value("line_period", exp_line, c - hfall_c);
                end_test("line_period", errs0);
                line_checked = 1'b1;
            end
            hfall_c = c;
        end
        if (!hsync_prev && hsync && hfall_c >= 0 && !hwidth_checked) begin
            errs0 = errors;
            check_value("hsync_width", exp_hsync_w, c - hfall_c);
            end_test("hsync_width", errs0);
            hwidth_checked = 1'b1;
        end
        if (!blank_prev && blank) begin
            brise_c = c;
            blank_lines++;
        end
        if (blank_prev && !blank) begin
            if (first_run < 0) first_run = c - brise_c;
            if (c - brise_c != exp_active) bad_runs++;
        end
        if (!blank && {red, green, blue} != 24'h0) bad_black++;  // porch colours leaked
        if (!vsync_prev && vsync && vfall_c >= 0 && !vwidth_checked) begin
            errs0 = errors;
            check_value("vsync_width", exp_vsync_lines * exp_line, c - vfall_c);
            end_test("vsync_width", errs0);
            vwidth_checked = 1'b1;
        end
        if (vsync_prev && !vsync) begin
            if (vfall_c < 0) begin
                vfall_c = c;
                blank_lines = 0;  // count one whole frame from here
            end else begin
                errs0 = errors;
                check_value("frame_period", exp_frame_lines * exp_line, c - vfall_c);
                end_test("frame_period", errs0);
                errs0 = errors;
                check_value("blank_lines", vga_pkg::V_ACTIVE, blank_lines);
                end_test("blank_lines", errs0);
                run_done = 1'b1;
            end
        end
        hsync_prev = hsync;
        vsync_prev = vsync;
        blank_prev = blank;
    endtask

    // step c sees beat c on x_out/y_out and the pins for beat c-2
    task automatic run_frames();
        int c, h, v, key, hist_new;
        bit act;
        c = 0;
        while (!run_done) begin
            h = c % vga_pkg::H_TOTAL;
            v = (c / vga_pkg::H_TOTAL) % vga_pkg::V_TOTAL;
            act = (h < vga_pkg::H_ACTIVE) && (v < vga_pkg::V_ACTIVE);
            if (int'(x_out) != ((h < vga_pkg::H_ACTIVE) ? h : 0)) bad_coords++;
            if (int'(y_out) != ((v < vga_pkg::V_ACTIVE) ? v : 0)) bad_coords++;
            if (c < 2) check_idle("after reset");
            if (c == 1) end_test("reset_state", reset_errs);
            color_in = next_color;  // answer for beat c-1
            key = v * 1024 + h;
            if (act && c < FRAME_CYCLES && pix_at.exists(key)) begin
                next_color = pix_col[pix_at[key]];
                hist_new = pix_at[key];
            end else begin
                take_lfsr_byte(next_color);
                hist_new = -1;
            end
            if (hist2 >= 0) check_pixel(hist2);
            watch_pins(c);
            hist2 = hist1;
            hist1 = hist_new;
            @(posedge clk);
            #1;
            c++;
        end
    endtask

    initial begin
        int errs0;
        rst = 1'b1;
        color_in = '0;
        next_color = '0;
        lfsr_state = 16'd12266;
        hist1 = -1;
        hist2 = -1;
        hfall_c = -1;
        vfall_c = -1;
        first_run = -1;
        {hsync_prev, vsync_prev, blank_prev} = 3'b110;
        load_cases();
        repeat (5) @(posedge clk);
        #1;
        reset_errs = errors;
        check_idle("in reset");
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        if (file_ok) begin
            run_frames();
            errs0 = errors;
            check_value("blank_run first", exp_active, first_run);
            check_value("blank_run bad lines", 0, bad_runs);
            end_test("blank_run", errs0);
            errs0 = errors;
            check_value("blank_black nonzero cycles", 0, bad_black);
            end_test("blank_black", errs0);
            errs0 = errors;
            check_value("coordinate mismatches", 0, bad_coords);
            end_test("coordinates", errs0);
            for (int k = 0; k < pix_count; k++) begin
                if (!pix_seen[k]) begin
                    $display("pixel test %s was never reached", pix_name[k]);
                    errors++;
                end
            end
        end
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < LIMIT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, two vsync pulses never appeared", cycle_count);
        $display("Simulation failed");
        $finish;
    end

endmodule
